//--- result_arbiter_pkg.sv
// Shared definitions for the tile result collector
// Widths, tile count, tile index type and collection states
package result_arbiter_pkg;

    // --------------------------------------------------
    // Tile population
    // --------------------------------------------------
    // Number of compute tiles feeding the collector
    localparam int NUM_TILES = 4;
    localparam int TILE_IDX_W = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;

    // Index of one tile
    typedef logic [TILE_IDX_W-1:0] tile_idx_t;

    // --------------------------------------------------
    // Data and counter widths
    // --------------------------------------------------
    // FP16 result word
    localparam int DATA_W = 16;
    // Tile FIFO occupancy, 0 to 256
    localparam int FIFO_CNT_W = 9;
    // Batch length B and column length C
    localparam int DIM_W = 8;
    // Per-tile result count, also holds B x C
    localparam int RESULT_CNT_W = 16;

    // Reads in flight per tile, bounded by the FIFO read latency
    localparam int MAX_PENDING = 2;
    localparam int PEND_W = $clog2(MAX_PENDING + 1);

    // Collection FSM states
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_COLLECT,
        ARB_DONE
    } arb_state_t;

endpackage : result_arbiter_pkg

//--- tile_fifo_tracker.sv
// Per-tile bookkeeping for the result collector
// Shadow FIFO counts, pending reads, result and chunk counters
// Readiness flags for the scheduler, taken from the next counter values
module tile_fifo_tracker (
    input  logic i_clk,
    input  logic i_reset_n,
    input  logic i_start,
    input  logic [result_arbiter_pkg::FIFO_CNT_W-1:0]
                 i_tile_fifo_count [result_arbiter_pkg::NUM_TILES],
    input  logic i_ce_result_valid [result_arbiter_pkg::NUM_TILES],
    input  logic i_issue,
    input  result_arbiter_pkg::tile_idx_t i_issue_tile,
    input  logic i_return,
    input  result_arbiter_pkg::tile_idx_t i_return_tile,
    input  logic i_advance,
    input  result_arbiter_pkg::tile_idx_t i_advance_tile,
    input  logic [result_arbiter_pkg::DIM_W-1:0] i_c_len,
    input  logic [result_arbiter_pkg::RESULT_CNT_W-1:0] i_results_per_tile,
    output logic [result_arbiter_pkg::NUM_TILES-1:0] o_can_read,
    output logic [result_arbiter_pkg::NUM_TILES-1:0] o_chunk_full,
    output logic [result_arbiter_pkg::NUM_TILES-1:0] o_tile_finished
);
    import result_arbiter_pkg::*;

    // Registered counters, one set per tile
    logic [FIFO_CNT_W-1:0]   shadow_cnt [NUM_TILES];
    logic [PEND_W-1:0]       pend_cnt   [NUM_TILES];
    logic [RESULT_CNT_W-1:0] result_cnt [NUM_TILES];
    logic [DIM_W-1:0]        chunk_cnt  [NUM_TILES];

    // Values the counters take at the next edge
    logic [FIFO_CNT_W-1:0]   shadow_nxt [NUM_TILES];
    logic [PEND_W-1:0]       pend_nxt   [NUM_TILES];
    logic [RESULT_CNT_W-1:0] result_nxt [NUM_TILES];
    logic [DIM_W-1:0]        chunk_nxt  [NUM_TILES];

    // Decoded strobes per tile
    logic [NUM_TILES-1:0] issue_hit;
    logic [NUM_TILES-1:0] return_hit;
    logic [NUM_TILES-1:0] advance_hit;

    always_comb begin
        for (int i = 0; i < NUM_TILES; i++) begin
            issue_hit[i]   = i_issue && (i_issue_tile == tile_idx_t'(i));
            return_hit[i]  = i_return && (i_return_tile == tile_idx_t'(i));
            advance_hit[i] = i_advance && (i_advance_tile == tile_idx_t'(i));
        end
    end

    // --------------------------------------------------
    // Next counter values
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_TILES; i++) begin
            // Physical count lags two cycles, so it only seeds the shadow on start
            shadow_nxt[i] = (i_start ? i_tile_fifo_count[i] : shadow_cnt[i])
                          + FIFO_CNT_W'(i_ce_result_valid[i])
                          - FIFO_CNT_W'(issue_hit[i]);
            // In-flight reads of the previous command still return after a start
            pend_nxt[i] = pend_cnt[i] + PEND_W'(issue_hit[i]) - PEND_W'(return_hit[i]);
            result_nxt[i] = i_start ? '0 : result_cnt[i] + RESULT_CNT_W'(issue_hit[i]);
            // An advance on the same cycle as the filling read wins
            if (i_start || advance_hit[i]) begin
                chunk_nxt[i] = '0;
            end else begin
                chunk_nxt[i] = chunk_cnt[i] + DIM_W'(issue_hit[i]);
            end
        end
    end

    // --------------------------------------------------
    // Readiness flags
    // --------------------------------------------------
    // Flags see the read on the wire this cycle, so the scheduler never double issues
    always_comb begin
        for (int i = 0; i < NUM_TILES; i++) begin
            o_can_read[i]      = (shadow_nxt[i] != '0) && (pend_nxt[i] < PEND_W'(MAX_PENDING));
            o_chunk_full[i]    = (chunk_nxt[i] >= i_c_len);
            o_tile_finished[i] = (result_nxt[i] >= i_results_per_tile);
        end
    end

    // --------------------------------------------------
    // Counter registers
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int i = 0; i < NUM_TILES; i++) begin
                shadow_cnt[i] <= '0;
                pend_cnt[i]   <= '0;
                result_cnt[i] <= '0;
                chunk_cnt[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_TILES; i++) begin
                shadow_cnt[i] <= shadow_nxt[i];
                pend_cnt[i]   <= pend_nxt[i];
                result_cnt[i] <= result_nxt[i];
                chunk_cnt[i]  <= chunk_nxt[i];
            end
        end
    end

endmodule : tile_fifo_tracker

//--- collect_scheduler.sv
// Collection FSM for the result collector
// Command capture, chunked round-robin pointer and read enable issue
module collect_scheduler (
    input  logic i_clk,
    input  logic i_reset_n,
    input  logic i_cmd_valid,
    input  logic [result_arbiter_pkg::NUM_TILES-1:0] i_cmd_tile_en,
    input  logic [result_arbiter_pkg::DIM_W-1:0] i_cmd_b,
    input  logic [result_arbiter_pkg::DIM_W-1:0] i_cmd_c,
    input  logic [result_arbiter_pkg::NUM_TILES-1:0] i_can_read,
    input  logic [result_arbiter_pkg::NUM_TILES-1:0] i_chunk_full,
    input  logic [result_arbiter_pkg::NUM_TILES-1:0] i_tile_finished,
    input  logic i_result_fifo_full,
    output logic o_start,
    output logic [result_arbiter_pkg::DIM_W-1:0] o_c_len,
    output logic [result_arbiter_pkg::RESULT_CNT_W-1:0] o_results_per_tile,
    output logic o_tile_fifo_rd_en [result_arbiter_pkg::NUM_TILES],
    output logic o_issue,
    output result_arbiter_pkg::tile_idx_t o_issue_tile,
    output logic o_advance,
    output result_arbiter_pkg::tile_idx_t o_advance_tile
);
    import result_arbiter_pkg::*;

    arb_state_t state;
    // Captured enable mask and round-robin pointer
    logic [NUM_TILES-1:0] tile_en;
    tile_idx_t cur_tile;
    tile_idx_t next_tile;

    // Per-cycle decisions
    logic cmd_accept;
    logic all_done;
    logic cur_en;
    logic do_skip;
    logic do_issue;
    logic do_advance;

    // Nearest enabled tile above the given one, wrapping; itself if none other
    function automatic tile_idx_t next_enabled(input tile_idx_t from,
                                               input logic [NUM_TILES-1:0] mask);
        tile_idx_t idx;
        tile_idx_t found;
        found = from;
        // Farthest first, so the nearest hit is the one kept
        for (int k = NUM_TILES - 1; k >= 1; k--) begin
            idx = tile_idx_t'((int'(from) + k) % NUM_TILES);
            if (mask[idx]) begin
                found = idx;
            end
        end
        return found;
    endfunction

    // --------------------------------------------------
    // Decision logic
    // --------------------------------------------------
    always_comb begin
        // Commands are ignored while a collection runs
        cmd_accept = i_cmd_valid && (|i_cmd_tile_en) && (state != ARB_COLLECT);
        all_done   = &(~tile_en | i_tile_finished);
        cur_en     = tile_en[cur_tile];
        next_tile  = next_enabled(cur_tile, tile_en);
        do_skip    = 1'b0;
        do_issue   = 1'b0;
        do_advance = 1'b0;
        if ((state == ARB_COLLECT) && !all_done) begin
            if (!cur_en) begin
                // Disabled tile, step past it
                do_skip = 1'b1;
            end else if (i_chunk_full[cur_tile]) begin
                // Chunk of C done, including one filled by the read on the wire
                do_advance = 1'b1;
            end else if (i_tile_finished[cur_tile]) begin
                // Tile has all B x C results, leave mid-chunk
                do_advance = 1'b1;
            end else if (i_can_read[cur_tile] && !i_result_fifo_full) begin
                do_issue = 1'b1;
            end
            // Otherwise wait on data, pending reads or downstream room
        end
    end

    // --------------------------------------------------
    // FSM, pointer and registered strobes
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state          <= ARB_IDLE;
            tile_en        <= '0;
            cur_tile       <= '0;
            o_start        <= 1'b0;
            o_issue        <= 1'b0;
            o_issue_tile   <= '0;
            o_advance      <= 1'b0;
            o_advance_tile <= '0;
            for (int i = 0; i < NUM_TILES; i++) begin
                o_tile_fifo_rd_en[i] <= 1'b0;
            end
        end else begin
            o_start        <= cmd_accept;
            o_issue        <= do_issue;
            o_issue_tile   <= cur_tile;
            o_advance      <= do_advance;
            o_advance_tile <= cur_tile;
            // One-hot read enable for the current tile
            for (int i = 0; i < NUM_TILES; i++) begin
                o_tile_fifo_rd_en[i] <= do_issue && (cur_tile == tile_idx_t'(i));
            end
            if (do_skip || do_advance) begin
                cur_tile <= next_tile;
            end
            case (state)
                ARB_IDLE, ARB_DONE: begin
                    // DONE takes the next command directly
                    if (cmd_accept) begin
                        state    <= ARB_COLLECT;
                        tile_en  <= i_cmd_tile_en;
                        cur_tile <= '0;
                    end
                end
                ARB_COLLECT: begin
                    if (all_done) begin
                        state <= ARB_DONE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Command dimensions, held for the whole collection
    always_ff @(posedge i_clk) begin
        if (cmd_accept) begin
            o_c_len            <= i_cmd_c;
            o_results_per_tile <= RESULT_CNT_W'(i_cmd_b) * RESULT_CNT_W'(i_cmd_c);
        end
    end

endmodule : collect_scheduler

//--- read_return_pipe.sv
// Read tracking pipeline matching the tile FIFO read latency
// Return strobe to the tracker and registered result output
module read_return_pipe (
    input  logic i_clk,
    input  logic i_reset_n,
    input  logic i_issue,
    input  result_arbiter_pkg::tile_idx_t i_issue_tile,
    input  logic [result_arbiter_pkg::DATA_W-1:0]
                 i_tile_fifo_rd_data [result_arbiter_pkg::NUM_TILES],
    output logic o_return,
    output result_arbiter_pkg::tile_idx_t o_return_tile,
    output logic [result_arbiter_pkg::DATA_W-1:0] o_result_data,
    output logic o_result_valid
);
    import result_arbiter_pkg::*;

    // Stage 1 lines up with FIFO data, stage 2 with the registered output
    logic      s1_valid;
    logic      s2_valid;
    tile_idx_t s1_tile;
    tile_idx_t s2_tile;
    logic [DATA_W-1:0] data_q;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_issue;
            s2_valid <= s1_valid;
        end
    end

    // Tile index and data follow the valids, back-to-back reads overlap
    always_ff @(posedge i_clk) begin
        s1_tile <= i_issue_tile;
        s2_tile <= s1_tile;
        if (s1_valid) begin
            data_q <= i_tile_fifo_rd_data[s1_tile];
        end
    end

    assign o_return       = s2_valid;
    assign o_return_tile  = s2_tile;
    assign o_result_valid = s2_valid;
    assign o_result_data  = data_q;

endmodule : read_return_pipe

//--- result_arbiter.sv
// Top level of the tile result collector
// Connects the scheduler, the per-tile tracker and the read return pipeline
module result_arbiter (
    input  logic i_clk,
    input  logic i_reset_n,
    // Command strobe
    input  logic i_cmd_valid,
    input  logic [result_arbiter_pkg::NUM_TILES-1:0] i_cmd_tile_en,
    input  logic [result_arbiter_pkg::DIM_W-1:0] i_cmd_b,
    input  logic [result_arbiter_pkg::DIM_W-1:0] i_cmd_c,
    // Tile FIFOs
    output logic o_tile_fifo_rd_en [result_arbiter_pkg::NUM_TILES],
    input  logic [result_arbiter_pkg::DATA_W-1:0]
                 i_tile_fifo_rd_data [result_arbiter_pkg::NUM_TILES],
    input  logic [result_arbiter_pkg::FIFO_CNT_W-1:0]
                 i_tile_fifo_count [result_arbiter_pkg::NUM_TILES],
    input  logic i_ce_result_valid [result_arbiter_pkg::NUM_TILES],
    // Shared result port
    output logic [result_arbiter_pkg::DATA_W-1:0] o_result_data,
    output logic o_result_valid,
    input  logic i_result_fifo_full
);
    import result_arbiter_pkg::*;

    // --------------------------------------------------
    // Internal wires
    // --------------------------------------------------
    logic start;
    logic [DIM_W-1:0] c_len;
    logic [RESULT_CNT_W-1:0] results_per_tile;
    logic issue;
    tile_idx_t issue_tile;
    logic advance;
    tile_idx_t advance_tile;
    logic ret;
    tile_idx_t ret_tile;
    // Readiness flags back to the scheduler
    logic [NUM_TILES-1:0] can_read;
    logic [NUM_TILES-1:0] chunk_full;
    logic [NUM_TILES-1:0] tile_finished;

    collect_scheduler i_collect_scheduler (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_cmd_valid        (i_cmd_valid),
        .i_cmd_tile_en      (i_cmd_tile_en),
        .i_cmd_b            (i_cmd_b),
        .i_cmd_c            (i_cmd_c),
        .i_can_read         (can_read),
        .i_chunk_full       (chunk_full),
        .i_tile_finished    (tile_finished),
        .i_result_fifo_full (i_result_fifo_full),
        .o_start            (start),
        .o_c_len            (c_len),
        .o_results_per_tile (results_per_tile),
        .o_tile_fifo_rd_en  (o_tile_fifo_rd_en),
        .o_issue            (issue),
        .o_issue_tile       (issue_tile),
        .o_advance          (advance),
        .o_advance_tile     (advance_tile)
    );

    tile_fifo_tracker i_tile_fifo_tracker (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_start            (start),
        .i_tile_fifo_count  (i_tile_fifo_count),
        .i_ce_result_valid  (i_ce_result_valid),
        .i_issue            (issue),
        .i_issue_tile       (issue_tile),
        .i_return           (ret),
        .i_return_tile      (ret_tile),
        .i_advance          (advance),
        .i_advance_tile     (advance_tile),
        .i_c_len            (c_len),
        .i_results_per_tile (results_per_tile),
        .o_can_read         (can_read),
        .o_chunk_full       (chunk_full),
        .o_tile_finished    (tile_finished)
    );

    // Results leave two cycles after each read enable
    read_return_pipe i_read_return_pipe (
        .i_clk               (i_clk),
        .i_reset_n           (i_reset_n),
        .i_issue             (issue),
        .i_issue_tile        (issue_tile),
        .i_tile_fifo_rd_data (i_tile_fifo_rd_data),
        .o_return            (ret),
        .o_return_tile       (ret_tile),
        .o_result_data       (o_result_data),
        .o_result_valid      (o_result_valid)
    );

endmodule : result_arbiter

//--- tb_clock_gen.sv
// Free-running testbench clock
// Period of 10 time units, starts low
module tb_clock_gen (
    output logic o_clk
);

    // Half of the 10 unit period
    localparam int HALF_PERIOD = 5;

    initial begin
        o_clk = 1'b0;
    end

    always #HALF_PERIOD o_clk = ~o_clk;

endmodule : tb_clock_gen

//--- tb_result_checker.sv
// Monitor for the tile result collector testbench
// Rebuilds the chunked round-robin order from the observed tile writes
// Checks read enable rules, result latency and values, counts tests
module tb_result_checker (
    input  logic i_clk,
    input  logic i_reset_n,
    input  logic i_cmd_valid,
    input  logic [result_arbiter_pkg::NUM_TILES-1:0] i_cmd_tile_en,
    input  logic [result_arbiter_pkg::DIM_W-1:0] i_cmd_b,
    input  logic [result_arbiter_pkg::DIM_W-1:0] i_cmd_c,
    input  logic i_rd_en [result_arbiter_pkg::NUM_TILES],
    input  logic i_wr_valid [result_arbiter_pkg::NUM_TILES],
    input  logic [result_arbiter_pkg::DATA_W-1:0] i_wr_data [result_arbiter_pkg::NUM_TILES],
    input  logic [result_arbiter_pkg::DATA_W-1:0] i_result_data,
    input  logic i_result_valid,
    input  logic i_result_fifo_full,
    output int   o_tests_done,
    output int   o_tests_failed,
    output int   o_errors
);
    import result_arbiter_pkg::*;

    // Values each tile wrote, in write order
    logic [DATA_W-1:0] wr_log [NUM_TILES][1024];
    int wr_cnt [NUM_TILES];
    int rd_cnt [NUM_TILES];
    // Written values already matched to a result
    int used_cnt [NUM_TILES];

    // Current command
    logic [NUM_TILES-1:0] mask;
    int b_len;
    int c_len;
    int exp_total;
    int pos;
    int rd_total;
    int test_num;
    int err_at_start;

    // Totals
    int tests_done;
    int tests_failed;
    int errors;

    // Read enable history for the two-cycle latency check
    logic rd_d1;
    logic rd_d2;
    logic full_q;
    int n_rd;
    int tile;
    int row_len;
    logic [DATA_W-1:0] expected;

    // Position of the n-th set bit of the mask, counting from tile 0
    function automatic int nth_enabled_tile(input logic [NUM_TILES-1:0] en, input int n);
        int seen;
        int found;
        seen = 0;
        found = 0;
        for (int k = 0; k < NUM_TILES; k++) begin
            if (en[k]) begin
                if (seen == n) begin
                    found = k;
                end
                seen++;
            end
        end
        return found;
    endfunction

    always @(posedge i_clk) begin
        if (!i_reset_n) begin
            rd_d1     = 1'b0;
            rd_d2     = 1'b0;
            full_q    = 1'b0;
            mask      = '0;
            exp_total = 0;
        end else begin
            // --------------------------------------------------
            // Tile writes and new commands
            // --------------------------------------------------
            for (int t = 0; t < NUM_TILES; t++) begin
                if (i_wr_valid[t]) begin
                    wr_log[t][wr_cnt[t]] = i_wr_data[t];
                    wr_cnt[t]++;
                end
            end
            if (i_cmd_valid) begin
                mask         = i_cmd_tile_en;
                b_len        = int'(i_cmd_b);
                c_len        = int'(i_cmd_c);
                exp_total    = b_len * c_len * $countones(i_cmd_tile_en);
                pos          = 0;
                rd_total     = 0;
                test_num++;
                err_at_start = errors;
            end

            // --------------------------------------------------
            // Read enable rules
            // --------------------------------------------------
            n_rd = 0;
            for (int t = 0; t < NUM_TILES; t++) begin
                if (i_rd_en[t]) begin
                    n_rd++;
                    rd_cnt[t]++;
                    rd_total++;
                    if (!mask[t]) begin
                        $display("ERROR at %0t: disabled tile %0d was read", $time, t);
                        errors++;
                    end
                    if (rd_cnt[t] > wr_cnt[t]) begin
                        $display("ERROR at %0t: tile %0d read more often than written",
                                 $time, t);
                        errors++;
                    end
                    // Full as the DUT saw it when it registered this read
                    if (full_q) begin
                        $display("ERROR at %0t: tile %0d read while result FIFO full",
                                 $time, t);
                        errors++;
                    end
                end
            end
            if (n_rd > 1) begin
                $display("ERROR at %0t: %0d read enables high together", $time, n_rd);
                errors++;
            end
            if (n_rd != 0 && rd_total > exp_total) begin
                $display("ERROR at %0t: read enable after the last result of test %0d",
                         $time, test_num);
                errors++;
            end

            // Valid must trail a read enable by exactly two cycles
            if (i_result_valid != rd_d2) begin
                $display("ERROR at %0t: result valid not two cycles after a read enable",
                         $time);
                errors++;
            end
            rd_d2  = rd_d1;
            rd_d1  = (n_rd != 0);
            full_q = i_result_fifo_full;

            // --------------------------------------------------
            // Result order and values
            // --------------------------------------------------
            if (i_result_valid) begin
                if (pos >= exp_total) begin
                    $display("ERROR at %0t: result beyond the expected count", $time);
                    errors++;
                end else begin
                    // Row of C per enabled tile, tiles in ascending order
                    row_len = $countones(mask) * c_len;
                    tile    = nth_enabled_tile(mask, (pos % row_len) / c_len);
                    if (used_cnt[tile] >= wr_cnt[tile]) begin
                        $display("ERROR at %0t: result for tile %0d with no unread write",
                                 $time, tile);
                        errors++;
                    end else begin
                        expected = wr_log[tile][used_cnt[tile]];
                        used_cnt[tile]++;
                        if (i_result_data !== expected) begin
                            $display("MISMATCH at %0t: test %0d result %0d tile %0d exp %h got %h",
                                     $time, test_num, pos, tile, expected, i_result_data);
                            errors++;
                        end
                    end
                    pos++;
                    if (pos == exp_total) begin
                        $display("test %0d: mask %b B %0d C %0d, %0d results, %s",
                                 test_num, mask, b_len, c_len, exp_total,
                                 (errors == err_at_start) ? "pass" : "fail");
                        tests_done++;
                        if (errors != err_at_start) begin
                            tests_failed++;
                        end
                    end
                end
            end
        end
        o_tests_done   <= tests_done;
        o_tests_failed <= tests_failed;
        o_errors       <= errors;
    end

endmodule : tb_result_checker

//--- tb_result_arbiter.sv
// Testbench top for the tile result collector
// Tile FIFO models with lagging counts, seeded random commands and writes
// Random result FIFO full, cycle limit on the whole run
module tb_result_arbiter;
    import result_arbiter_pkg::*;

    localparam int NUM_CMDS = 12;

    logic clk;
    logic reset_n;
    logic cmd_valid;
    logic [NUM_TILES-1:0] cmd_tile_en;
    logic [DIM_W-1:0] cmd_b;
    logic [DIM_W-1:0] cmd_c;
    logic rd_en [NUM_TILES];
    logic [DATA_W-1:0] rd_data [NUM_TILES];
    logic [FIFO_CNT_W-1:0] fifo_count [NUM_TILES];
    logic ce_valid [NUM_TILES];
    logic [DATA_W-1:0] wr_data [NUM_TILES];
    logic [DATA_W-1:0] result_data;
    logic result_valid;
    logic result_fifo_full;

    // Tile FIFO models of 256 entries
    logic [DATA_W-1:0] fifo_mem [NUM_TILES][256];
    logic [7:0] fifo_wp [NUM_TILES];
    logic [7:0] fifo_rp [NUM_TILES];
    logic [FIFO_CNT_W-1:0] fifo_cnt [NUM_TILES];
    logic [FIFO_CNT_W-1:0] cnt_d1 [NUM_TILES];

    // Command list and write progress
    logic [NUM_TILES-1:0] mask_list [NUM_CMDS];
    int b_list [NUM_CMDS];
    int c_list [NUM_CMDS];
    int writes_left [NUM_TILES];
    int wr_seq [NUM_TILES];
    int total_results;
    int timeout_limit;
    int cycle_cnt = 0;
    int tests_done;
    int tests_failed;
    int error_count;

    tb_clock_gen i_tb_clock_gen (.o_clk(clk));

    result_arbiter i_result_arbiter (
        .i_clk              (clk),
        .i_reset_n          (reset_n),
        .i_cmd_valid        (cmd_valid),
        .i_cmd_tile_en      (cmd_tile_en),
        .i_cmd_b            (cmd_b),
        .i_cmd_c            (cmd_c),
        .o_tile_fifo_rd_en  (rd_en),
        .i_tile_fifo_rd_data(rd_data),
        .i_tile_fifo_count  (fifo_count),
        .i_ce_result_valid  (ce_valid),
        .o_result_data      (result_data),
        .o_result_valid     (result_valid),
        .i_result_fifo_full (result_fifo_full)
    );

    tb_result_checker i_tb_result_checker (
        .i_clk              (clk),
        .i_reset_n          (reset_n),
        .i_cmd_valid        (cmd_valid),
        .i_cmd_tile_en      (cmd_tile_en),
        .i_cmd_b            (cmd_b),
        .i_cmd_c            (cmd_c),
        .i_rd_en            (rd_en),
        .i_wr_valid         (ce_valid),
        .i_wr_data          (wr_data),
        .i_result_data      (result_data),
        .i_result_valid     (result_valid),
        .i_result_fifo_full (result_fifo_full),
        .o_tests_done       (tests_done),
        .o_tests_failed     (tests_failed),
        .o_errors           (error_count)
    );

    // --------------------------------------------------
    // Tile FIFO models
    // --------------------------------------------------
    // Data one cycle after rd_en, count seen two cycles late
    always @(posedge clk) begin
        for (int t = 0; t < NUM_TILES; t++) begin
            if (!reset_n) begin
                fifo_wp[t]    <= '0;
                fifo_rp[t]    <= '0;
                fifo_cnt[t]   <= '0;
                cnt_d1[t]     <= '0;
                fifo_count[t] <= '0;
                rd_data[t]    <= '0;
            end else begin
                if (rd_en[t]) begin
                    rd_data[t] <= fifo_mem[t][fifo_rp[t]];
                    fifo_rp[t] <= fifo_rp[t] + 8'd1;
                end
                if (ce_valid[t]) begin
                    fifo_mem[t][fifo_wp[t]] <= wr_data[t];
                    fifo_wp[t] <= fifo_wp[t] + 8'd1;
                end
                fifo_cnt[t]   <= fifo_cnt[t] + FIFO_CNT_W'(ce_valid[t])
                               - FIFO_CNT_W'(rd_en[t]);
                cnt_d1[t]     <= fifo_cnt[t];
                fifo_count[t] <= cnt_d1[t];
            end
        end
    end

    // Cycle limit for a stalled run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout: results still missing after %0d cycles", cycle_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // One command, then random writes and full until its last result
    task automatic run_command(input int n);
        @(posedge clk);
        cmd_valid   <= 1'b1;
        cmd_tile_en <= mask_list[n];
        cmd_b       <= DIM_W'(b_list[n]);
        cmd_c       <= DIM_W'(c_list[n]);
        @(posedge clk);
        cmd_valid <= 1'b0;
        // Writes begin after the shadow counts are seeded from the lagging count
        repeat (2) @(posedge clk);
        for (int t = 0; t < NUM_TILES; t++) begin
            writes_left[t] = mask_list[n][t] ? b_list[n] * c_list[n] : 0;
        end
        while (tests_done < n + 1) begin
            @(posedge clk);
            for (int t = 0; t < NUM_TILES; t++) begin
                if (writes_left[t] > 0 && ($urandom % 2 == 0)) begin
                    ce_valid[t] <= 1'b1;
                    // Per-tile base keeps the tiles apart in the output
                    wr_data[t]  <= DATA_W'(16'h1000 * (t + 1) + wr_seq[t]);
                    wr_seq[t]++;
                    writes_left[t]--;
                end else begin
                    ce_valid[t] <= 1'b0;
                end
            end
            result_fifo_full <= ($urandom % 4 == 0);
        end
        result_fifo_full <= 1'b0;
    endtask

    initial begin
        void'($urandom(2));
        reset_n          = 1'b0;
        cmd_valid        = 1'b0;
        cmd_tile_en      = '0;
        cmd_b            = '0;
        cmd_c            = '0;
        result_fifo_full = 1'b0;
        for (int t = 0; t < NUM_TILES; t++) begin
            ce_valid[t]    = 1'b0;
            wr_data[t]     = '0;
            fifo_count[t]  = '0;
            rd_data[t]     = '0;
            wr_seq[t]      = 0;
            writes_left[t] = 0;
        end
        // Single tile, all tiles, two split masks, then random masks
        mask_list[0] = 'b0100;
        mask_list[1] = '1;
        mask_list[2] = 'b1010;
        mask_list[3] = 'b1001;
        total_results = 0;
        for (int n = 0; n < NUM_CMDS; n++) begin
            if (n >= 4) begin
                mask_list[n] = NUM_TILES'(1 + $urandom % ((1 << NUM_TILES) - 1));
            end
            b_list[n] = 1 + $urandom % 4;
            c_list[n] = 1 + $urandom % 4;
            total_results += b_list[n] * c_list[n] * $countones(mask_list[n]);
        end
        timeout_limit = 20 * total_results + 200;

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        for (int n = 0; n < NUM_CMDS; n++) begin
            run_command(n);
        end
        // Idle cycles expose any stray read after the last result
        repeat (20) @(posedge clk);

        $display("Tests run %0d of %0d, failed %0d, errors %0d",
                 tests_done, NUM_CMDS, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_done == NUM_CMDS) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_result_arbiter

//--- result_arbiter.f
result_arbiter_pkg.sv
tile_fifo_tracker.sv
collect_scheduler.sv
read_return_pipe.sv
result_arbiter.sv
tb_clock_gen.sv
tb_result_checker.sv
tb_result_arbiter.sv

//--- Bender.yml
package:
  name: result_arbiter

sources:
  - result_arbiter_pkg.sv
  - tile_fifo_tracker.sv
  - collect_scheduler.sv
  - read_return_pipe.sv
  - result_arbiter.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_result_checker.sv
      - tb_result_arbiter.sv
